//--- src/ioSettings.svh
// I/O write stage settings

`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// Data word and address sizes
`define IO_WORD_WIDTH       36
`define IO_ADDR_WIDTH       10

// Memory-mapped write port window at the top of the address space
`define IO_PORT_COUNT       4
`define IO_PORT_ADDR_WIDTH  2
`define IO_PORT_BASE_ADDR   1020

// The RAM spans every address, including the port window
`define IO_RAM_DEPTH        1024

// Port flag encodings
`define IO_EMPTY            1'b1
`define IO_FULL             1'b0

`endif

//--- src/ioPkg.sv
// I/O address types

`include "ioSettings.svh"

`default_nettype none

package ioPkg;

    // Field view of an address: the window tag on top, the port index below
    typedef struct packed {
        logic [`IO_ADDR_WIDTH-`IO_PORT_ADDR_WIDTH-1:0] tag;
        logic [`IO_PORT_ADDR_WIDTH-1:0]                port;
    } ioAddrFields;

    // One address word, read either whole or split into fields
    typedef union packed {
        logic [`IO_ADDR_WIDTH-1:0] raw;
        ioAddrFields               fields;
    } ioAddr;

endpackage

`default_nettype wire

//--- src/ioCheck.sv
// I/O address check and flag select

`include "ioSettings.svh"

`default_nettype none

module ioCheck #(
    // Flag value reported when the address is not an I/O port
    parameter logic readyState = `IO_EMPTY
) (
    input  wire                       clock,
    input  wire                       rst,
    input  ioPkg::ioAddr              addr,
    input  wire [`IO_PORT_COUNT-1:0]  portEf,
    output logic                      portEfMasked,
    output logic                      addrIsIo,
    output logic                      addrIsIoReg
);

    localparam int tagWidth = `IO_ADDR_WIDTH - `IO_PORT_ADDR_WIDTH;

    // The window is aligned to the port count, so the tag alone identifies it
    localparam logic [tagWidth-1:0] windowTag =
        tagWidth'(`IO_PORT_BASE_ADDR >> `IO_PORT_ADDR_WIDTH);

    always_comb begin
        addrIsIo = (addr.fields.tag == windowTag);
    end

    // Outside the window the pipeline must never stall, so report ready
    always_comb begin
        if (addrIsIo) begin
            portEfMasked = portEf[addr.fields.port];
        end else begin
            portEfMasked = readyState;
        end
    end

    // Match travels one stage further with the instruction
    always_ff @(posedge clock) begin
        if (rst) begin
            addrIsIoReg <= 1'b0;
        end else begin
            addrIsIoReg <= addrIsIo;
        end
    end

endmodule

`default_nettype wire

//--- src/ioActive.sv
// I/O port enable decode

`include "ioSettings.svh"

`default_nettype none

module ioActive (
    input  wire                        clock,
    input  wire                        rst,
    input  wire                        enable,
    input  ioPkg::ioAddr               addr,
    output logic [`IO_PORT_COUNT-1:0]  active
);

    localparam int tagWidth = `IO_ADDR_WIDTH - `IO_PORT_ADDR_WIDTH;

    localparam logic [tagWidth-1:0] windowTag =
        tagWidth'(`IO_PORT_BASE_ADDR >> `IO_PORT_ADDR_WIDTH);

    logic [`IO_PORT_COUNT-1:0] activeNext;

    // At most one port is selected, and only for an enabled write into the window
    always_comb begin
        activeNext = '0;
        if (enable && (addr.fields.tag == windowTag)) begin
            activeNext[addr.fields.port] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            active <= '0;
        end else begin
            active <= activeNext;
        end
    end

endmodule

`default_nettype wire

//--- src/ioWrite.sv
// I/O write stage

`include "ioSettings.svh"

`default_nettype none

module ioWrite (
    input  wire                                          clock,
    input  wire                                          rst,
    input  wire  [`IO_ADDR_WIDTH-1:0]                    addrRaw,
    input  wire  [`IO_PORT_COUNT-1:0]                    emptyFull,
    input  wire                                          ioReady,
    input  wire  [`IO_WORD_WIDTH-1:0]                    aluResult,
    input  wire  [`IO_ADDR_WIDTH-1:0]                    aluAddr,
    input  wire                                          aluWriteIsIo,
    input  wire                                          aluWren,
    output logic                                         writeIsIo,
    output logic                                         emptyFullMasked,
    output logic [`IO_PORT_COUNT-1:0]                    activeIo,
    output logic [`IO_PORT_COUNT*`IO_WORD_WIDTH-1:0]     dataIo,
    output logic [`IO_WORD_WIDTH-1:0]                    dataRam,
    output logic [`IO_ADDR_WIDTH-1:0]                    addrRam,
    output logic                                         wrenRam
);

    ioPkg::ioAddr checkAddr;
    ioPkg::ioAddr storeAddr;
    logic         addrIsIoReg;
    logic         writeIsIoStage;
    logic         ioEnable;

    assign checkAddr.raw = addrRaw;
    assign storeAddr.raw = aluAddr;

    // Early decode of the store destination, straight from the raw instruction
    ioCheck #(
        .readyState   (`IO_EMPTY)
    ) check (
        .clock        (clock),
        .rst          (rst),
        .addr         (checkAddr),
        .portEf       (emptyFull),
        .portEfMasked (emptyFullMasked),
        .addrIsIo     (),
        .addrIsIoReg  (addrIsIoReg)
    );

    // The flag rides the pipeline to the ALU entrance and comes back with the result
    always_ff @(posedge clock) begin
        if (rst) begin
            writeIsIoStage <= 1'b0;
            writeIsIo      <= 1'b0;
        end else begin
            writeIsIoStage <= addrIsIoReg & ioReady;
            writeIsIo      <= writeIsIoStage;
        end
    end

    always_ff @(posedge clock) begin
        dataRam <= aluResult;
        addrRam <= storeAddr.raw;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wrenRam <= 1'b0;
        end else begin
            wrenRam <= aluWren;
        end
    end

    // Each port gets its own copy register, which keeps fanout low at the ports
    for (genvar p = 0; p < `IO_PORT_COUNT; p++) begin : portCopy
        always_ff @(posedge clock) begin
            dataIo[p*`IO_WORD_WIDTH +: `IO_WORD_WIDTH] <= aluResult;
        end
    end

    assign ioEnable = aluWriteIsIo & aluWren;

    ioActive portEnable (
        .clock  (clock),
        .rst    (rst),
        .enable (ioEnable),
        .addr   (storeAddr),
        .active (activeIo)
    );

endmodule

`default_nettype wire

//--- src/dataRam.sv
// Data memory

`include "ioSettings.svh"

`default_nettype none

module dataRam (
    input  wire                         clock,
    input  wire                         wren,
    input  ioPkg::ioAddr                writeAddr,
    input  wire  [`IO_WORD_WIDTH-1:0]   writeData,
    input  ioPkg::ioAddr                readAddr,
    output logic [`IO_WORD_WIDTH-1:0]   readData
);

    logic [`IO_WORD_WIDTH-1:0] mem [`IO_RAM_DEPTH];

    // Port window addresses are stored like any other location
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[writeAddr.raw] <= writeData;
        end
    end

    // Registered read, so the result shows up one cycle after the address
    always_ff @(posedge clock) begin
        readData <= mem[readAddr.raw];
    end

endmodule

`default_nettype wire

//--- src/ioWriteUnit.sv
// I/O write unit top level

`include "ioSettings.svh"

`default_nettype none

module ioWriteUnit (
    input  wire                                          clock,
    input  wire                                          rst,
    input  wire  [`IO_ADDR_WIDTH-1:0]                    addrRaw,
    input  wire  [`IO_PORT_COUNT-1:0]                    emptyFull,
    input  wire                                          ioReady,
    input  wire  [`IO_WORD_WIDTH-1:0]                    aluResult,
    input  wire  [`IO_ADDR_WIDTH-1:0]                    aluAddr,
    input  wire                                          aluWriteIsIo,
    input  wire                                          aluWren,
    output wire                                          writeIsIo,
    output wire                                          emptyFullMasked,
    output wire  [`IO_PORT_COUNT-1:0]                    activeIo,
    output wire  [`IO_PORT_COUNT*`IO_WORD_WIDTH-1:0]     dataIo,
    input  wire  [`IO_ADDR_WIDTH-1:0]                    readAddr,
    output wire  [`IO_WORD_WIDTH-1:0]                    readData
);

    wire [`IO_WORD_WIDTH-1:0] ramData;
    wire [`IO_ADDR_WIDTH-1:0] ramAddr;
    wire                      ramWren;

    ioWrite writeStage (
        .clock           (clock),
        .rst             (rst),
        .addrRaw         (addrRaw),
        .emptyFull       (emptyFull),
        .ioReady         (ioReady),
        .aluResult       (aluResult),
        .aluAddr         (aluAddr),
        .aluWriteIsIo    (aluWriteIsIo),
        .aluWren         (aluWren),
        .writeIsIo       (writeIsIo),
        .emptyFullMasked (emptyFullMasked),
        .activeIo        (activeIo),
        .dataIo          (dataIo),
        .dataRam         (ramData),
        .addrRam         (ramAddr),
        .wrenRam         (ramWren)
    );

    // Read port is brought out only so that the stored words can be observed
    dataRam ram (
        .clock     (clock),
        .wren      (ramWren),
        .writeAddr (ramAddr),
        .writeData (ramData),
        .readAddr  (readAddr),
        .readData  (readData)
    );

endmodule

`default_nettype wire

//--- verif/ioWriteChecker.sv
// I/O write unit checker

`include "ioSettings.svh"

`default_nettype none

module ioWriteChecker (
    input  wire                                      clock,
    input  wire                                      rst,
    input  int                                       testId,
    input  wire                                      readCheck,
    input  wire  [`IO_ADDR_WIDTH-1:0]                addrRaw,
    input  wire  [`IO_PORT_COUNT-1:0]                emptyFull,
    input  wire                                      ioReady,
    input  wire  [`IO_WORD_WIDTH-1:0]                aluResult,
    input  wire  [`IO_ADDR_WIDTH-1:0]                aluAddr,
    input  wire                                      aluWriteIsIo,
    input  wire                                      aluWren,
    input  wire  [`IO_ADDR_WIDTH-1:0]                readAddr,
    input  wire                                      writeIsIo,
    input  wire                                      emptyFullMasked,
    input  wire  [`IO_PORT_COUNT-1:0]                activeIo,
    input  wire  [`IO_PORT_COUNT*`IO_WORD_WIDTH-1:0] dataIo,
    input  wire  [`IO_WORD_WIDTH-1:0]                readData,
    output int                                       errorCount,
    output int                                       checkCount,
    output int                                       readCount
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int wideWidth = `IO_PORT_COUNT * `IO_WORD_WIDTH;
    localparam int portBits  = `IO_PORT_ADDR_WIDTH;

    logic [`IO_WORD_WIDTH-1:0]  memModel [`IO_RAM_DEPTH];
    bit                         written [`IO_RAM_DEPTH];
    logic [2:0]                 matchHist;
    logic [1:0]                 readyHist;
    logic                       expFlag;
    logic [`IO_PORT_COUNT-1:0]  expActive;
    logic [wideWidth-1:0]       expData;
    bit                         expDataValid = 1'b0;
    logic [`IO_WORD_WIDTH-1:0]  expRead;
    bit                         expReadValid = 1'b0;
    bit                         primed = 1'b0;
    int                         errors = 0;
    int                         checks = 0;
    int                         reads = 0;
    int                         lastTestId = 0;
    int                         testErrors = 0;
    int                         testChecks = 0;

    assign errorCount = errors;
    assign checkCount = checks;
    assign readCount  = reads;

    function automatic logic inWindow(input logic [`IO_ADDR_WIDTH-1:0] addr);
        int a;
        a = int'(addr);
        return (a >= `IO_PORT_BASE_ADDR) && (a < `IO_PORT_BASE_ADDR + `IO_PORT_COUNT);
    endfunction

    function automatic logic [portBits-1:0] portOf(input logic [`IO_ADDR_WIDTH-1:0] addr);
        return portBits'(int'(addr) - `IO_PORT_BASE_ADDR);
    endfunction

    // Outside the window the pipeline sees the ready state
    function automatic logic expectedFlag(input logic [`IO_ADDR_WIDTH-1:0] addr,
                                          input logic [`IO_PORT_COUNT-1:0] flags);
        if (inWindow(addr)) begin
            return flags[portOf(addr)];
        end
        return `IO_EMPTY;
    endfunction

    function automatic logic [`IO_PORT_COUNT-1:0] expectedEnable(
        input logic [`IO_ADDR_WIDTH-1:0] addr,
        input logic                      isIo,
        input logic                      wren
    );
        logic [`IO_PORT_COUNT-1:0] v;
        v = '0;
        if (isIo && wren && inWindow(addr)) begin
            v[portOf(addr)] = 1'b1;
        end
        return v;
    endfunction

    function automatic string testName(input int id);
        case (id)
            1:       return "reset";
            2:       return "flagSelect";
            3:       return "flagPath";
            4:       return "portWrite";
            5:       return "ramReadback";
            default: return "idle";
        endcase
    endfunction

    task automatic compare(input string what, input logic [wideWidth-1:0] expected,
                           input logic [wideWidth-1:0] actual);
        checks++;
        testChecks++;
        if (expected !== actual) begin
            errors++;
            testErrors++;
            $display("[ERROR] %s: %s expected %0h actual %0h",
                     testName(testId), what, expected, actual);
        end
    endtask

    // Build the expected values from the inputs of the cycle that just ended
    always @(posedge clock) begin
        expRead      = memModel[readAddr];
        expReadValid = readCheck && written[readAddr];
        if (rst) begin
            matchHist    = '0;
            readyHist    = '0;
            expFlag      = 1'b0;
            expActive    = '0;
            expDataValid = 1'b0;
        end else begin
            matchHist    = {matchHist[1:0], inWindow(addrRaw)};
            readyHist    = {readyHist[0], ioReady};
            expFlag      = matchHist[2] & readyHist[1];
            expActive    = expectedEnable(aluAddr, aluWriteIsIo, aluWren);
            expData      = {`IO_PORT_COUNT{aluResult}};
            expDataValid = 1'b1;
            if (aluWren) begin
                memModel[aluAddr] = aluResult;
                written[aluAddr]  = 1'b1;
            end
        end
        primed = 1'b1;
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clock) begin
        if (testId != lastTestId) begin
            if (lastTestId != 0) begin
                $display("Test %s finished: %0d checks, %0d errors",
                         testName(lastTestId), testChecks, testErrors);
            end
            testChecks = 0;
            testErrors = 0;
            lastTestId = testId;
        end
        if (primed) begin
            compare("emptyFullMasked", wideWidth'(expectedFlag(addrRaw, emptyFull)),
                    wideWidth'(emptyFullMasked));
            compare("writeIsIo", wideWidth'(expFlag), wideWidth'(writeIsIo));
            compare("activeIo", wideWidth'(expActive), wideWidth'(activeIo));
            if (expDataValid) begin
                compare("dataIo", expData, dataIo);
            end
            if (expReadValid) begin
                compare("readData", wideWidth'(expRead), wideWidth'(readData));
                reads++;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/ioWriteUnitTb.sv
// I/O write unit testbench

`include "ioSettings.svh"

`default_nettype none

module ioWriteUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int addrWidth   = `IO_ADDR_WIDTH;
    localparam int wordWidth   = `IO_WORD_WIDTH;
    localparam int portBits    = `IO_PORT_ADDR_WIDTH;
    localparam int cycleCount  = 200;
    localparam int burstCount  = 64;
    localparam int readTimeout = 100;

    logic                                      clock = 1'b0;
    logic                                      rst;
    logic [addrWidth-1:0]                      addrRaw;
    logic [`IO_PORT_COUNT-1:0]                 emptyFull;
    logic                                      ioReady;
    logic [wordWidth-1:0]                      aluResult;
    logic [addrWidth-1:0]                      aluAddr;
    logic                                      aluWriteIsIo;
    logic                                      aluWren;
    logic [addrWidth-1:0]                      readAddr;
    wire                                       writeIsIo;
    wire                                       emptyFullMasked;
    wire  [`IO_PORT_COUNT-1:0]                 activeIo;
    wire  [`IO_PORT_COUNT*`IO_WORD_WIDTH-1:0]  dataIo;
    wire  [wordWidth-1:0]                      readData;

    int                   seed = 1;
    int                   testId;
    logic                 readCheck;
    int                   errorCount;
    int                   checkCount;
    int                   readCount;
    bit                   timedOut;
    logic [addrWidth-1:0] storedAddrs [$];

    always #2 clock = ~clock;

    ioWriteUnit ioWriteUnit_inst (
        .clock(clock), .rst(rst), .addrRaw(addrRaw), .emptyFull(emptyFull),
        .ioReady(ioReady), .aluResult(aluResult), .aluAddr(aluAddr),
        .aluWriteIsIo(aluWriteIsIo), .aluWren(aluWren), .writeIsIo(writeIsIo),
        .emptyFullMasked(emptyFullMasked), .activeIo(activeIo), .dataIo(dataIo),
        .readAddr(readAddr), .readData(readData)
    );

    ioWriteChecker scoreboard (
        .clock(clock), .rst(rst), .testId(testId), .readCheck(readCheck),
        .addrRaw(addrRaw), .emptyFull(emptyFull), .ioReady(ioReady),
        .aluResult(aluResult), .aluAddr(aluAddr), .aluWriteIsIo(aluWriteIsIo),
        .aluWren(aluWren), .readAddr(readAddr), .writeIsIo(writeIsIo),
        .emptyFullMasked(emptyFullMasked), .activeIo(activeIo), .dataIo(dataIo),
        .readData(readData), .errorCount(errorCount), .checkCount(checkCount),
        .readCount(readCount)
    );

    function automatic logic [31:0] nextRandom();
        return $random(seed);
    endfunction

    // Half the addresses hit the port window; narrow ones repeat often
    function automatic logic [addrWidth-1:0] pickAddr(input bit narrow);
        logic [31:0] r;
        r = nextRandom();
        if (r[31]) begin
            return addrWidth'(`IO_PORT_BASE_ADDR + int'(r[portBits-1:0]));
        end else if (narrow) begin
            return addrWidth'(r[4:0]);
        end
        return r[addrWidth-1:0];
    endfunction

    task automatic nextCycle();
        @(posedge clock);
        #0.5;
    endtask

    task automatic driveIdle();
        addrRaw      = '0;
        emptyFull    = '0;
        ioReady      = 1'b0;
        aluResult    = '0;
        aluAddr      = '0;
        aluWriteIsIo = 1'b0;
        aluWren      = 1'b0;
    endtask

    task automatic randomFlagSide();
        logic [31:0] r;
        r         = nextRandom();
        addrRaw   = pickAddr(1'b0);
        emptyFull = r[`IO_PORT_COUNT-1:0];
        ioReady   = r[8];
    endtask

    task automatic randomStore(input bit narrow);
        logic [31:0] r;
        r            = nextRandom();
        aluWren      = r[0] | r[1];
        aluWriteIsIo = r[2];
        aluAddr      = pickAddr(narrow);
        aluResult    = wordWidth'({nextRandom(), r});
    endtask

    task automatic runTest(input int id, input bit flagSide, input bit storeSide);
        testId = id;
        repeat (cycleCount) begin
            if (flagSide) begin
                randomFlagSide();
            end
            if (storeSide) begin
                randomStore(1'b0);
            end
            nextCycle();
        end
        driveIdle();
        repeat (4) nextCycle();
    endtask

    task automatic waitForReads(input int target, output bit expired);
        int waited;
        waited = 0;
        while (readCount < target && waited < readTimeout) begin
            nextCycle();
            waited++;
        end
        expired = (readCount < target);
        if (expired) begin
            $display("Timeout: only %0d of %0d RAM read-back results arrived", readCount, target);
        end
    endtask

    task automatic runReadback(output bit expired);
        int target;
        testId = 5;
        repeat (burstCount) begin
            randomStore(1'b1);
            if (aluWren) begin
                storedAddrs.push_back(aluAddr);
            end
            nextCycle();
        end
        driveIdle();
        // Let the last stores land in RAM before reading
        repeat (3) nextCycle();
        target = readCount + storedAddrs.size();
        foreach (storedAddrs[i]) begin
            readAddr  = storedAddrs[i];
            readCheck = 1'b1;
            nextCycle();
        end
        readCheck = 1'b0;
        waitForReads(target, expired);
        repeat (2) nextCycle();
    endtask

    initial begin
        driveIdle();
        rst       = 1'b1;
        readAddr  = '0;
        readCheck = 1'b0;
        testId    = 1;
        timedOut  = 1'b0;
        // An enabled port store held through reset must not reach the control outputs
        addrRaw      = addrWidth'(`IO_PORT_BASE_ADDR);
        ioReady      = 1'b1;
        aluAddr      = addrWidth'(`IO_PORT_BASE_ADDR);
        aluWriteIsIo = 1'b1;
        aluWren      = 1'b1;
        repeat (2) @(posedge clock);
        #0.5;
        driveIdle();
        rst = 1'b0;
        repeat (4) nextCycle();
        runTest(2, 1'b1, 1'b0);
        runTest(3, 1'b1, 1'b0);
        runTest(4, 1'b0, 1'b1);
        runReadback(timedOut);
        testId = 0;
        repeat (3) nextCycle();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (!timedOut && errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ioWriteUnit.f
+incdir+src
src/ioPkg.sv
src/ioCheck.sv
src/ioActive.sv
src/ioWrite.sv
src/dataRam.sv
src/ioWriteUnit.sv
verif/ioWriteChecker.sv
verif/ioWriteUnitTb.sv

//--- Makefile
# Verilator build and run for the I/O write unit

VERILATOR ?= verilator
TOP       ?= ioWriteUnitTb
FILELIST  ?= ioWriteUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BINARY)
	@rm -f $(LOG)
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qxF '** PASS **' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
